/* filelist.f */
+incdir+include
source/pa_pkg.sv
source/pa_regs_if.sv
source/pa_bus_w.sv
source/pa_bus_a.sv
source/pa_alu.sv
source/pa_regs.sv
source/pa_addr.sv
source/pa.sv
verif/pa_tb.sv

/* include/pa_defs.svh */
/*
	P-A arithmetic unit widths and step constants.
	Bit 0 is the most significant bit throughout the datapath.
*/

`ifndef PA_DEFS_SVH
`define PA_DEFS_SVH

// full datapath width
`define PA_W 16

// short argument held in ir bits 10..15
`define PA_SHORT_W 6

// step of the AR minus-four order
`define PA_AR_STEP4 4

`endif

/* run.sh */
#!/bin/sh
# build and run the P-A testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f filelist.f --top-module pa_tb -o pa_sim
./obj_dir/pa_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
	exit 1
fi
exit 0

/* source/pa.sv */
/*
	P-A arithmetic unit, top level.
	W and A bus multiplexers, ALU, registers and address output.
*/

`timescale 1ns/1ns
`include "pa_defs.svh"

module pa (
	input  logic              strob1,
	input  logic              rst_n,
	input  logic [0:`PA_W-1]  ir,
	input  logic [0:`PA_W-1]  kl,
	input  logic [0:`PA_W-1]  rdt,
	input  logic [0:`PA_W-1]  ki,
	input  logic [0:`PA_W-1]  l,
	input  pa_pkg::w_src_e    w_sel,
	input  pa_pkg::a_src_e    a_sel,
	input  pa_pkg::alu_op_e   op,
	input  pa_pkg::ad_src_e   ad_sel,
	input  logic              p16,
	input  logic              ad_en,
	input  logic              barnb,
	input  logic              ac_load,
	input  logic              at_load,
	input  logic              ar_load,
	input  logic              ar_inc,
	input  logic              ar_dec4,
	input  logic              ic_load,
	input  logic              ic_inc,
	input  logic              ic_clr,
	input  logic              wzi_en,
	output logic [0:`PA_W-1]  w,
	output logic [0:`PA_W-1]  a,
	output logic [0:`PA_W-1]  f,
	output logic [0:`PA_W-1]  dad,
	output logic              carry,
	output logic              s0,
	output logic              zs,
	output logic              wzi,
	output logic              zga,
	output logic              arz,
	output logic              at15
);

	pa_regs_if regs_if ();

	pa_bus_a bus_a_i (
		.a_sel (a_sel),
		.ir    (ir),
		.l     (l),
		.regs  (regs_if.reader),
		.a     (a)
	);

	pa_bus_w bus_w_i (
		.w_sel (w_sel),
		.ir    (ir),
		.kl    (kl),
		.rdt   (rdt),
		.ki    (ki),
		.a     (a),
		.regs  (regs_if.reader),
		.w     (w)
	);

	pa_alu alu_i (
		.op    (op),
		.a     (a),
		.ac    (regs_if.ac),
		.p16   (p16),
		.f     (f),
		.carry (carry),
		.s0    (s0),
		.zs    (zs)
	);

	pa_regs regs_i (
		.strob1  (strob1),
		.rst_n   (rst_n),
		.w       (w),
		.f       (f),
		.ac_load (ac_load),
		.at_load (at_load),
		.ar_load (ar_load),
		.ar_inc  (ar_inc),
		.ar_dec4 (ar_dec4),
		.ic_load (ic_load),
		.ic_inc  (ic_inc),
		.ic_clr  (ic_clr),
		.wzi_en  (wzi_en),
		.zs      (zs),
		.wzi     (wzi),
		.arz     (arz),
		.at15    (at15),
		.regs    (regs_if.owner)
	);

	pa_addr addr_i (
		.ad_sel (ad_sel),
		.ad_en  (ad_en),
		.ar     (regs_if.ar),
		.ic     (regs_if.ic),
		.kl     (kl),
		.barnb  (barnb),
		.dad    (dad),
		.zga    (zga)
	);

endmodule

/* source/pa_addr.sv */
/*
	P-A address output.
	Drives AR or IC onto the address lines and flags a key-address match.
*/

`timescale 1ns/1ns
`include "pa_defs.svh"

module pa_addr (
	input  pa_pkg::ad_src_e   ad_sel,
	input  logic              ad_en,
	input  logic [0:`PA_W-1]  ar,
	input  logic [0:`PA_W-1]  ic,
	input  logic [0:`PA_W-1]  kl,
	input  logic              barnb,
	output logic [0:`PA_W-1]  dad,
	output logic              zga
);

	always_comb begin
		if (!ad_en)
			dad = '0;
		else if (ad_sel == pa_pkg::AD_AR)
			dad = ar;
		else
			dad = ic;
	end

	// memory block bit replaces the top address bit in the stop compare
	assign zga = (kl == {barnb, dad[1:`PA_W-1]});

endmodule

/* source/pa_alu.sv */
/*
	P-A ALU.
	Add and subtract with carry, bitwise logic, and sign and zero flags.
*/

`timescale 1ns/1ns
`include "pa_defs.svh"

module pa_alu (
	input  pa_pkg::alu_op_e   op,
	input  logic [0:`PA_W-1]  a,
	input  logic [0:`PA_W-1]  ac,
	input  logic              p16,
	output logic [0:`PA_W-1]  f,
	output logic              carry,
	output logic              s0,
	output logic              zs
);

	// one extra bit on the left holds the carry out of bit 0
	logic [0:`PA_W] sum;
	logic [0:`PA_W] dif;

	assign sum = {1'b0, a} + {1'b0, ac} + (`PA_W+1)'(p16);

	// a - ac - p16 as a + ~ac + ~p16
	assign dif = {1'b0, a} + {1'b0, ~ac} + {{`PA_W{1'b0}}, ~p16};

	always_comb begin
		carry = 1'b0;
		case (op)
			pa_pkg::OP_ADD: begin
				f = sum[1:`PA_W];
				carry = sum[0];
			end
			pa_pkg::OP_SUB: begin
				f = dif[1:`PA_W];
				carry = dif[0];
			end
			pa_pkg::OP_AND: begin
				f = a & ac;
			end
			pa_pkg::OP_OR: begin
				f = a | ac;
			end
			pa_pkg::OP_XOR: begin
				f = a ^ ac;
			end
			default: begin
				// pass A for the spare codes too
				f = a;
			end
		endcase
	end

	assign s0 = f[0];
	assign zs = (f == '0);

endmodule

/* source/pa_bus_a.sv */
/*
	P-A A bus multiplexer.
	Selects AR, IC, the L literal or the sign-extended short argument.
*/

`timescale 1ns/1ns
`include "pa_defs.svh"

module pa_bus_a (
	input  pa_pkg::a_src_e    a_sel,
	input  logic [0:`PA_W-1]  ir,
	input  logic [0:`PA_W-1]  l,
	pa_regs_if.reader         regs,
	output logic [0:`PA_W-1]  a
);

	logic [0:`PA_SHORT_W-1] short_arg;
	logic [0:`PA_W-1]       short_ext;

	// short argument sits in the low end of ir, its sign in the leftmost bit
	assign short_arg = ir[`PA_W-`PA_SHORT_W:`PA_W-1];
	assign short_ext = {{(`PA_W-`PA_SHORT_W){short_arg[0]}}, short_arg};

	always_comb begin
		case (a_sel)
			pa_pkg::A_AR:    a = regs.ar;
			pa_pkg::A_IC:    a = regs.ic;
			pa_pkg::A_L:     a = l;
			pa_pkg::A_SHORT: a = short_ext;
			default:         a = '0;
		endcase
	end

endmodule

/* source/pa_bus_w.sv */
/*
	P-A W bus multiplexer.
	Picks the W bus from IR, keys, memory data, I/O bus, AT, AC or A.
*/

`timescale 1ns/1ns
`include "pa_defs.svh"

module pa_bus_w (
	input  pa_pkg::w_src_e    w_sel,
	input  logic [0:`PA_W-1]  ir,
	input  logic [0:`PA_W-1]  kl,
	input  logic [0:`PA_W-1]  rdt,
	input  logic [0:`PA_W-1]  ki,
	input  logic [0:`PA_W-1]  a,
	pa_regs_if.reader         regs,
	output logic [0:`PA_W-1]  w
);

	always_comb begin
		case (w_sel)
			pa_pkg::W_IR:  w = ir;
			pa_pkg::W_KL:  w = kl;
			pa_pkg::W_RDT: w = rdt;
			pa_pkg::W_KI:  w = ki;
			pa_pkg::W_AT:  w = regs.at;
			pa_pkg::W_AC:  w = regs.ac;
			pa_pkg::W_A:   w = a;
			// unused code leaves the bus idle
			default:       w = '0;
		endcase
	end

	// the control source must never select the spare code
	always_comb begin
		w_sel_chk: assert (w_sel inside {pa_pkg::W_IR, pa_pkg::W_KL, pa_pkg::W_RDT,
			pa_pkg::W_KI, pa_pkg::W_AT, pa_pkg::W_AC, pa_pkg::W_A})
			else $error("pa_bus_w: undefined W source %0d", w_sel);
	end

endmodule

/* source/pa_pkg.sv */
/*
	P-A arithmetic unit types.
	Source selects for the W, A and address buses, and the ALU operations.
*/

package pa_pkg;

	// W bus sources
	typedef enum logic [2:0] {
		W_IR  = 3'd0,
		W_KL  = 3'd1,
		W_RDT = 3'd2,
		W_KI  = 3'd3,
		W_AT  = 3'd4,
		W_AC  = 3'd5,
		W_A   = 3'd6
	} w_src_e;

	// A bus sources
	typedef enum logic [1:0] {
		A_AR    = 2'd0,
		A_IC    = 2'd1,
		A_L     = 2'd2,
		A_SHORT = 2'd3
	} a_src_e;

	typedef enum logic [2:0] {
		OP_PASS_A = 3'd0,
		OP_ADD    = 3'd1,
		OP_SUB    = 3'd2,
		OP_AND    = 3'd3,
		OP_OR     = 3'd4,
		OP_XOR    = 3'd5
	} alu_op_e;

	// address output source
	typedef enum logic {
		AD_AR = 1'b0,
		AD_IC = 1'b1
	} ad_src_e;

endpackage

/* source/pa_regs.sv */
/*
	P-A register block.
	AC, AT, AR and IC with load and counting orders, plus the WZI zero latch.
*/

`timescale 1ns/1ns
`include "pa_defs.svh"

module pa_regs (
	input  logic              strob1,
	input  logic              rst_n,
	input  logic [0:`PA_W-1]  w,
	input  logic [0:`PA_W-1]  f,
	input  logic              ac_load,
	input  logic              at_load,
	input  logic              ar_load,
	input  logic              ar_inc,
	input  logic              ar_dec4,
	input  logic              ic_load,
	input  logic              ic_inc,
	input  logic              ic_clr,
	input  logic              wzi_en,
	input  logic              zs,
	output logic              wzi,
	output logic              arz,
	output logic              at15,
	pa_regs_if.owner          regs
);

	logic [0:`PA_W-1] ac_q;
	logic [0:`PA_W-1] at_q;
	logic [0:`PA_W-1] ar_q;
	logic [0:`PA_W-1] ic_q;
	logic             wzi_q;

	always_ff @(posedge strob1 or negedge rst_n) begin
		if (!rst_n) begin
			ac_q <= '0;
			at_q <= '0;
		end else begin
			if (ac_load)
				ac_q <= w;
			if (at_load)
				at_q <= f;
		end
	end

	// AR: load wins over +1, +1 wins over -4
	always_ff @(posedge strob1 or negedge rst_n) begin
		if (!rst_n)
			ar_q <= '0;
		else if (ar_load)
			ar_q <= w;
		else if (ar_inc)
			ar_q <= ar_q + `PA_W'(1);
		else if (ar_dec4)
			ar_q <= ar_q - `PA_W'(`PA_AR_STEP4);
	end

	// IC: clear, then load, then +1
	always_ff @(posedge strob1 or negedge rst_n) begin
		if (!rst_n)
			ic_q <= '0;
		else if (ic_clr)
			ic_q <= '0;
		else if (ic_load)
			ic_q <= w;
		else if (ic_inc)
			ic_q <= ic_q + `PA_W'(1);
	end

	always_ff @(posedge strob1 or negedge rst_n) begin
		if (!rst_n)
			wzi_q <= 1'b0;
		else if (wzi_en)
			wzi_q <= zs;
	end

	assign regs.ac = ac_q;
	assign regs.at = at_q;
	assign regs.ar = ar_q;
	assign regs.ic = ic_q;
	assign wzi = wzi_q;

	// upper half of AR non-zero
	assign arz = |ar_q[0:7];
	assign at15 = at_q[`PA_W-1];

	// control should not ask for both directions at once
	ar_order_chk: assert property (@(posedge strob1) disable iff (!rst_n)
		!(ar_inc && ar_dec4))
		else $warning("pa_regs: ar_inc and ar_dec4 together");

	ic_order_chk: assert property (@(posedge strob1) disable iff (!rst_n)
		!(ic_inc && ic_load))
		else $warning("pa_regs: ic_inc and ic_load together");

	// zs comes from the ALU, so this ties the latch to the live flag
	wzi_follow_chk: assert property (@(posedge strob1) disable iff (!rst_n)
		wzi_en |=> (wzi == $past(zs)))
		else $error("pa_regs: WZI did not take zs");

endmodule

/* source/pa_regs_if.sv */
/*
	P-A register bundle.
	Carries AC, AT, AR and IC from the register block to the bus multiplexers.
*/

`timescale 1ns/1ns
`include "pa_defs.svh"

interface pa_regs_if;

	logic [0:`PA_W-1] ac;
	logic [0:`PA_W-1] at;
	logic [0:`PA_W-1] ar;
	logic [0:`PA_W-1] ic;

	// register block side
	modport owner (output ac, at, ar, ic);

	// bus multiplexer side
	modport reader (input ac, at, ar, ic);

endinterface

/* verif/pa_tb.sv */
/*
	Testbench for the P-A arithmetic unit.
	Directed and random orders, checked every cycle against a shadow model.
*/

`timescale 1ns/1ns
`include "pa_defs.svh"

module pa_tb;

	typedef logic [0:`PA_W-1] word_t;

	logic strob1;
	logic rst_n;
	word_t ir, kl, rdt, ki, l;
	pa_pkg::w_src_e w_sel;
	pa_pkg::a_src_e a_sel;
	pa_pkg::alu_op_e op;
	pa_pkg::ad_src_e ad_sel;
	logic p16, ad_en, barnb;
	logic ac_load, at_load, ar_load, ar_inc, ar_dec4;
	logic ic_load, ic_inc, ic_clr, wzi_en;
	word_t w, a, f, dad;
	logic carry, s0, zs, wzi, zga, arz, at15;

	// shadow registers
	word_t m_ac, m_at, m_ar, m_ic;
	logic m_wzi;

	int errors;
	int timeouts;
	int check_count;

	pa dut_i (.*);

	always #20 strob1 = ~strob1;

	function automatic word_t rand_word();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = $urandom;
		return r[0];
	endfunction

	function automatic word_t a_ref(pa_pkg::a_src_e sel, word_t ir_v, word_t l_v,
		word_t ar_v, word_t ic_v);
		case (sel)
			pa_pkg::A_AR:    return ar_v;
			pa_pkg::A_IC:    return ic_v;
			pa_pkg::A_L:     return l_v;
			pa_pkg::A_SHORT: return word_t'($signed(ir_v[`PA_W-`PA_SHORT_W:`PA_W-1]));
			default:         return '0;
		endcase
	endfunction

	function automatic word_t w_ref(pa_pkg::w_src_e sel, word_t a_v, word_t at_v, word_t ac_v);
		case (sel)
			pa_pkg::W_IR:  return ir;
			pa_pkg::W_KL:  return kl;
			pa_pkg::W_RDT: return rdt;
			pa_pkg::W_KI:  return ki;
			pa_pkg::W_AT:  return at_v;
			pa_pkg::W_AC:  return ac_v;
			pa_pkg::W_A:   return a_v;
			default:       return '0;
		endcase
	endfunction

	// ALU result and flags with a no-borrow carry on subtract
	function automatic void alu_ref(input pa_pkg::alu_op_e o, input word_t x, input word_t y,
		input logic c_in, output word_t r, output logic c_out, output logic z);
		logic [`PA_W:0] total;
		logic [`PA_W:0] need;
		c_out = 1'b0;
		case (o)
			pa_pkg::OP_ADD: begin
				total = {1'b0, x} + {1'b0, y} + {{`PA_W{1'b0}}, c_in};
				r = total[`PA_W-1:0];
				c_out = total[`PA_W];
			end
			pa_pkg::OP_SUB: begin
				need = {1'b0, y} + {{`PA_W{1'b0}}, c_in};
				r = x - y - {{(`PA_W-1){1'b0}}, c_in};
				c_out = ({1'b0, x} >= need);
			end
			pa_pkg::OP_AND: r = x & y;
			pa_pkg::OP_OR:  r = x | y;
			pa_pkg::OP_XOR: r = x ^ y;
			default:        r = x;
		endcase
		z = (r == '0);
	endfunction

	// shadow model follows the register orders
	always @(posedge strob1 or negedge rst_n) begin
		word_t na;
		word_t nw;
		word_t nf;
		logic nc;
		logic nz;
		if (!rst_n) begin
			m_ac <= '0;
			m_at <= '0;
			m_ar <= '0;
			m_ic <= '0;
			m_wzi <= 1'b0;
		end else begin
			na = a_ref(a_sel, ir, l, m_ar, m_ic);
			nw = w_ref(w_sel, na, m_at, m_ac);
			alu_ref(op, na, m_ac, p16, nf, nc, nz);
			if (ac_load)
				m_ac <= nw;
			if (at_load)
				m_at <= nf;
			if (ar_load)
				m_ar <= nw;
			else if (ar_inc)
				m_ar <= m_ar + word_t'(1);
			else if (ar_dec4)
				m_ar <= m_ar - word_t'(`PA_AR_STEP4);
			if (ic_clr)
				m_ic <= '0;
			else if (ic_load)
				m_ic <= nw;
			else if (ic_inc)
				m_ic <= m_ic + word_t'(1);
			if (wzi_en)
				m_wzi <= nz;
		end
	end

	task automatic check(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_outputs();
		word_t ea;
		word_t ew;
		word_t ef;
		word_t ed;
		logic ec;
		logic ez;
		logic eg;
		ea = a_ref(a_sel, ir, l, m_ar, m_ic);
		ew = w_ref(w_sel, ea, m_at, m_ac);
		alu_ref(op, ea, m_ac, p16, ef, ec, ez);
		ed = !ad_en ? '0 : (ad_sel == pa_pkg::AD_AR ? m_ar : m_ic);
		eg = (kl[0] === barnb) && (kl[1:`PA_W-1] === ed[1:`PA_W-1]);
		check("a", a, ea);
		check("w", w, ew);
		check("f", f, ef);
		check("carry", `PA_W'(carry), `PA_W'(ec));
		check("s0", `PA_W'(s0), `PA_W'(ef[0]));
		check("zs", `PA_W'(zs), `PA_W'(ez));
		check("wzi", `PA_W'(wzi), `PA_W'(m_wzi));
		check("dad", dad, ed);
		check("zga", `PA_W'(zga), `PA_W'(eg));
		check("arz", `PA_W'(arz), `PA_W'(|m_ar[0:7]));
		check("at15", `PA_W'(at15), `PA_W'(m_at[`PA_W-1]));
	endtask

	// outputs are settled 5 ns before the falling edge
	always @(posedge strob1) begin
		#15;
		compare_outputs();
		check_count++;
	end

	// one cycle up to the falling edge after the next compare
	task automatic wait_cycle();
		int start;
		int n;
		start = check_count;
		n = 0;
		while (timeouts == 0 && check_count == start && n < 3) begin
			@(negedge strob1);
			n++;
		end
		if (timeouts == 0 && check_count == start) begin
			timeouts++;
			$display("timeout at %0t ns: no output compare within %0d cycles", $time, n);
		end
	endtask

	task automatic clear_orders();
		ac_load = 1'b0;
		at_load = 1'b0;
		ar_load = 1'b0;
		ar_inc = 1'b0;
		ar_dec4 = 1'b0;
		ic_load = 1'b0;
		ic_inc = 1'b0;
		ic_clr = 1'b0;
		wzi_en = 1'b0;
	endtask

	task automatic check_reset_state();
		check("reset w", w, '0);
		check("reset wzi", `PA_W'(wzi), '0);
		check("reset zs", `PA_W'(zs), `PA_W'(1'b1));
		check("reset arz", `PA_W'(arz), '0);
	endtask

	// AR and IC both loaded from the I/O bus
	task automatic load_ar_ic(input word_t v);
		ki = v;
		w_sel = pa_pkg::W_KI;
		ar_load = 1'b1;
		ic_load = 1'b1;
		wait_cycle();
		clear_orders();
	endtask

	task automatic read_a(input pa_pkg::a_src_e sel, input string name, input word_t exp);
		a_sel = sel;
		wait_cycle();
		check(name, a, exp);
	endtask

	task automatic check_addr(input pa_pkg::ad_src_e sel, input word_t exp);
		ad_en = 1'b1;
		ad_sel = sel;
		// block bit differs from the top address bit
		barnb = ~exp[0];
		kl = {barnb, exp[1:`PA_W-1]};
		wait_cycle();
		check("dad", dad, exp);
		check("zga equal", `PA_W'(zga), `PA_W'(1'b1));
		kl[`PA_W-1] = ~kl[`PA_W-1];
		wait_cycle();
		check("zga low bit", `PA_W'(zga), '0);
		kl = {~barnb, exp[1:`PA_W-1]};
		wait_cycle();
		check("zga block bit", `PA_W'(zga), '0);
	endtask

	task automatic drive_random();
		ir = rand_word();
		kl = rand_word();
		rdt = rand_word();
		ki = rand_word();
		l = rand_word();
		w_sel = pa_pkg::w_src_e'(3'($urandom_range(6, 0)));
		a_sel = pa_pkg::a_src_e'(2'($urandom_range(3, 0)));
		op = pa_pkg::alu_op_e'(3'($urandom_range(5, 0)));
		ad_sel = pa_pkg::ad_src_e'(rand_bit());
		p16 = rand_bit();
		ad_en = rand_bit();
		barnb = rand_bit();
		ac_load = rand_bit();
		at_load = rand_bit();
		ar_load = rand_bit();
		ar_inc = rand_bit();
		// opposite counting orders are kept apart
		ar_dec4 = rand_bit() & ~ar_inc;
		ic_load = rand_bit();
		ic_inc = rand_bit() & ~ic_load;
		ic_clr = ($urandom_range(7, 0) == 0);
		wzi_en = rand_bit();
	endtask

	initial begin
		word_t ac_val;
		word_t ef;
		word_t v;
		logic ec;
		logic ez;
		void'($urandom(84292));
		errors = 0;
		timeouts = 0;
		check_count = 0;
		strob1 = 1'b0;
		rst_n = 1'b0;
		ir = '0;
		kl = '0;
		rdt = '0;
		ki = '0;
		l = '0;
		w_sel = pa_pkg::W_AC;
		a_sel = pa_pkg::A_AR;
		op = pa_pkg::OP_PASS_A;
		ad_sel = pa_pkg::AD_AR;
		p16 = 1'b0;
		ad_en = 1'b0;
		barnb = 1'b0;
		clear_orders();

		// reset held for 16 cycles with AC and then AT on W
		repeat (8) wait_cycle();
		check_reset_state();
		w_sel = pa_pkg::W_AT;
		repeat (8) wait_cycle();
		check_reset_state();
		rst_n = 1'b1;
		wait_cycle();
		check_reset_state();

		// ALU with AC from the keys and A from the L literal
		for (int i = 0; i < 60; i++) begin
			ac_val = rand_word();
			kl = ac_val;
			w_sel = pa_pkg::W_KL;
			ac_load = 1'b1;
			wait_cycle();
			ac_load = 1'b0;
			l = rand_word();
			a_sel = pa_pkg::A_L;
			op = pa_pkg::alu_op_e'(3'(i % 6));
			p16 = rand_bit();
			wait_cycle();
			alu_ref(op, l, ac_val, p16, ef, ec, ez);
			check("alu f", f, ef);
			check("alu carry", `PA_W'(carry), `PA_W'(ec));
			check("alu s0", `PA_W'(s0), `PA_W'(ef[0]));
			check("alu zs", `PA_W'(zs), `PA_W'(ez));
		end

		// register loads read back through W and A
		rdt = rand_word();
		ir = rand_word();
		l = rand_word();
		op = pa_pkg::OP_PASS_A;
		w_sel = pa_pkg::W_RDT;
		ac_load = 1'b1;
		at_load = 1'b1;
		wait_cycle();
		clear_orders();
		v = rand_word();
		ki = v;
		w_sel = pa_pkg::W_KI;
		ar_load = 1'b1;
		wait_cycle();
		clear_orders();
		w_sel = pa_pkg::W_IR;
		ic_load = 1'b1;
		wait_cycle();
		clear_orders();
		w_sel = pa_pkg::W_AC;
		read_a(pa_pkg::A_AR, "ar load", v);
		check("ac load", w, rdt);
		w_sel = pa_pkg::W_AT;
		read_a(pa_pkg::A_IC, "ic load", ir);
		check("at load", w, l);
		read_a(pa_pkg::A_SHORT, "short arg", word_t'($signed(ir[`PA_W-`PA_SHORT_W:`PA_W-1])));

		// counting orders and their wrap at 16 bits
		load_ar_ic(16'hFFFF);
		ar_inc = 1'b1;
		ic_inc = 1'b1;
		wait_cycle();
		clear_orders();
		read_a(pa_pkg::A_AR, "ar inc wrap", 16'h0000);
		read_a(pa_pkg::A_IC, "ic inc wrap", 16'h0000);
		load_ar_ic(16'h0002);
		ar_dec4 = 1'b1;
		wait_cycle();
		clear_orders();
		read_a(pa_pkg::A_AR, "ar dec4 wrap", 16'hFFFE);
		ki = 16'h1234;
		w_sel = pa_pkg::W_KI;
		ar_load = 1'b1;
		ar_inc = 1'b1;
		ic_load = 1'b1;
		ic_clr = 1'b1;
		wait_cycle();
		clear_orders();
		read_a(pa_pkg::A_AR, "ar load first", 16'h1234);
		read_a(pa_pkg::A_IC, "ic clear first", 16'h0000);

		// address output and key stop compare
		v = rand_word();
		load_ar_ic(v);
		ic_inc = 1'b1;
		wait_cycle();
		clear_orders();
		check_addr(pa_pkg::AD_AR, v);
		check_addr(pa_pkg::AD_IC, v + word_t'(1));
		ad_en = 1'b0;
		wait_cycle();
		check("dad idle", dad, '0);

		// random orders and sources
		for (int i = 0; i < 400; i++) begin
			drive_random();
			wait_cycle();
		end
		clear_orders();
		wait_cycle();

		$display("checks %0d, mismatches %0d, timeouts %0d", check_count, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
